// ==== rtl/hub_macros.svh ====
/*
  spi peripheral hub shared constants
  frame geometry, register map and revision byte
*/

`ifndef HUB_MACROS_SVH
`define HUB_MACROS_SVH

// command frame is addr byte then value byte
`define HUB_FRAME_BITS 16

// adc03, dac, flash, adc02
`define HUB_PERIPHS 4

// register map
`define HUB_ADDR_LED      8'd7
`define HUB_ADDR_MUX      8'd8
`define HUB_ADDR_DAC      8'd9
`define HUB_ADDR_RAILS    8'd10
`define HUB_ADDR_SOFT_RST 8'd11
`define HUB_ADDR_REF_MUX  8'd12
`define HUB_ADDR_ADC      8'd14

// first byte of every reply
`define HUB_REV 8'hC3

`endif

// ==== rtl/hub_pkg.sv ====
/*
  hub types and the set/clear/toggle update rule
*/

`include "hub_macros.svh"

package hub_pkg;

  // frame halves
  typedef logic [7:0] addr_t;
  // high nibble clear mask, low nibble set mask
  typedef logic [7:0] val_t;

  typedef struct packed {
    addr_t addr;
    val_t  val;
  } frame_t;

  // rev byte, mux nibble, led nibble
  typedef logic [`HUB_FRAME_BITS-1:0] reply_t;

  typedef logic [3:0] led_t;
  typedef logic [3:0] ref_mux_t;

  // one select bit per routed peripheral
  typedef struct packed {
    logic adc02;
    logic flash;
    logic dac;
    logic adc03;
  } mux_t;

  typedef struct packed {
    logic rst;
    logic uni_bip_b;
    logic uni_bip_a;
    logic ldac;
  } dac_ctl_t;

  typedef struct packed {
    logic oe;
    logic lp60v;
    logic lp30v;
    logic lp15v;
  } rails_t;

  typedef struct packed {
    logic rst;
    logic m2;
    logic m1;
    logic m0;
  } adc_ctl_t;

  // per bit: set only -> 1, clear only -> 0, both -> invert, neither -> keep
  function automatic logic [3:0] apply_masks(logic [3:0] old, val_t val);
    logic [3:0] set_m;
    logic [3:0] clr_m;
    set_m = val[3:0];
    clr_m = val[7:4];
    return (old & ~set_m & ~clr_m) | (set_m & ~clr_m) | (~old & set_m & clr_m);
  endfunction

endpackage

// ==== rtl/spi_edge_sync.sv ====
/*
  spi pin synchronizer
  two flops per pin plus a history stage, registered edge and select events
*/

`timescale 1ns/1ps

module spi_edge_sync (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic special_n,
  input  logic mosi,
  output logic sck_rise,
  output logic sck_fall,
  output logic mosi_s,
  output logic frame_start,
  output logic frame_end,
  output logic cmd_sel
);

  // [0] and [1] sync, [2] history for edge detect
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [2:0] spec_q;
  logic [2:0] mosi_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // selects idle high, sck idles low
      sck_q  <= 3'b000;
      cs_q   <= 3'b111;
      spec_q <= 3'b111;
      mosi_q <= 3'b000;
    end
    else
    begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      spec_q <= {spec_q[1:0], special_n};
      mosi_q <= {mosi_q[1:0], mosi};
    end
  end

  //////////////////////////////
  // event pulses, third cycle after the pin edge
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sck_rise    <= 1'b0;
      sck_fall    <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end
    else
    begin
      sck_rise    <= sck_q[1] & ~sck_q[2];
      sck_fall    <= ~sck_q[1] & sck_q[2];
      // cs falling with special already low
      frame_start <= ~cs_q[1] & cs_q[2] & ~spec_q[1];
      // any cs release, rx ignores the ones that are not command frames
      frame_end   <= cs_q[1] & ~cs_q[2];
    end
  end

  // levels from the history stage line up with the pulses
  assign mosi_s  = mosi_q[2];
  assign cmd_sel = ~cs_q[2] & ~spec_q[2];

endmodule

// ==== rtl/ctrl_frame_rx.sv ====
/*
  command frame receiver
  shifts mosi in on sck rise, strobes frame_valid for exact 16 bit frames
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module ctrl_frame_rx (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           sck_rise,
  input  logic           mosi_s,
  input  logic           cmd_sel,
  input  logic           frame_start,
  input  logic           frame_end,
  output logic           frame_valid,
  output hub_pkg::addr_t addr,
  output hub_pkg::val_t  val
);

  import hub_pkg::*;

  // one spare bit so 17 and longer never look like 16
  localparam int cnt_w = $clog2(`HUB_FRAME_BITS) + 1;

  logic [`HUB_FRAME_BITS-1:0] shift_q;
  logic [cnt_w-1:0]           bit_cnt;
  logic                       cnt_sat;
  frame_t                     frame;

  assign cnt_sat = &bit_cnt;

  // msb first, lsb in
  always_ff @(posedge clk)
  begin
    if (sck_rise && cmd_sel)
      shift_q <= {shift_q[`HUB_FRAME_BITS-2:0], mosi_s};
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      // exact length check before the count is dropped
      frame_valid <= frame_end && (bit_cnt == cnt_w'(`HUB_FRAME_BITS));
      // clear at both ends so pass-through frames see zero
      if (frame_start || frame_end)
        bit_cnt <= '0;
      else if (sck_rise && cmd_sel && !cnt_sat)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // no sck between last bit and strobe, fields stay put
  assign frame = frame_t'(shift_q);
  assign addr  = frame.addr;
  assign val   = frame.val;

endmodule

// ==== rtl/ctrl_reply_tx.sv ====
/*
  reply serializer
  captures rev, mux and led at frame start, shifts out msb first on sck fall
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module ctrl_reply_tx (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          sck_fall,
  input  logic          cmd_sel,
  input  logic          frame_start,
  input  hub_pkg::mux_t mux,
  input  hub_pkg::led_t led,
  output logic          hub_dout
);

  import hub_pkg::*;

  reply_t shift_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      shift_q <= '0;
    else if (frame_start)
      // snapshot before this frame can change anything
      shift_q <= {`HUB_REV, mux, led};
    else if (sck_fall && cmd_sel)
      // zero fill from the bottom
      shift_q <= shift_q << 1;
  end

  // msb valid well before the next rising sck
  assign hub_dout = shift_q[$bits(reply_t)-1];

endmodule

// ==== rtl/ctrl_field_reg.sv ====
/*
  one 4 bit control field
  mask update on hit, clear on soft reset
*/

`timescale 1ns/1ps

module ctrl_field_reg #(
  parameter type field_t = logic [3:0]
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          hit,
  input  logic          soft_rst,
  input  hub_pkg::val_t val,
  output field_t        q
);

  import hub_pkg::*;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      q <= field_t'('0);
    else if (soft_rst)
      // soft reset wins over any hit
      q <= field_t'('0);
    else if (hit)
      q <= field_t'(apply_masks(q, val));
  end

endmodule

// ==== rtl/ctrl_reg_bank.sv ====
/*
  control register bank
  decodes frame address into field hits and the soft reset
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module ctrl_reg_bank (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              frame_valid,
  input  hub_pkg::addr_t    addr,
  input  hub_pkg::val_t     val,
  output hub_pkg::led_t     led,
  output hub_pkg::mux_t     mux,
  output hub_pkg::dac_ctl_t dac,
  output hub_pkg::rails_t   rails,
  output hub_pkg::ref_mux_t ref_mux,
  output hub_pkg::adc_ctl_t adc
);

  import hub_pkg::*;

  logic hit_led;
  logic hit_mux;
  logic hit_dac;
  logic hit_rails;
  logic hit_ref_mux;
  logic hit_adc;
  logic soft_rst;

  //////////////////////////////
  // address decode, unknown addresses fall through
  assign hit_led     = frame_valid && (addr == `HUB_ADDR_LED);
  assign hit_mux     = frame_valid && (addr == `HUB_ADDR_MUX);
  assign hit_dac     = frame_valid && (addr == `HUB_ADDR_DAC);
  assign hit_rails   = frame_valid && (addr == `HUB_ADDR_RAILS);
  assign hit_ref_mux = frame_valid && (addr == `HUB_ADDR_REF_MUX);
  assign hit_adc     = frame_valid && (addr == `HUB_ADDR_ADC);
  assign soft_rst    = frame_valid && (addr == `HUB_ADDR_SOFT_RST);

  //////////////////////////////
  // fields
  ctrl_field_reg #(.field_t(led_t)) led_reg_i (
    .clk(clk), .arst_n(arst_n), .hit(hit_led), .soft_rst(soft_rst), .val(val), .q(led)
  );

  // peripheral select bits
  ctrl_field_reg #(.field_t(mux_t)) mux_reg_i (
    .clk(clk), .arst_n(arst_n), .hit(hit_mux), .soft_rst(soft_rst), .val(val), .q(mux)
  );

  ctrl_field_reg #(.field_t(dac_ctl_t)) dac_reg_i (
    .clk(clk), .arst_n(arst_n), .hit(hit_dac), .soft_rst(soft_rst), .val(val), .q(dac)
  );

  // rails come up with oe low after soft reset
  ctrl_field_reg #(.field_t(rails_t)) rails_reg_i (
    .clk(clk), .arst_n(arst_n), .hit(hit_rails), .soft_rst(soft_rst), .val(val), .q(rails)
  );

  ctrl_field_reg #(.field_t(ref_mux_t)) ref_mux_reg_i (
    .clk(clk), .arst_n(arst_n), .hit(hit_ref_mux), .soft_rst(soft_rst), .val(val),
    .q(ref_mux)
  );

  ctrl_field_reg #(.field_t(adc_ctl_t)) adc_reg_i (
    .clk(clk), .arst_n(arst_n), .hit(hit_adc), .soft_rst(soft_rst), .val(val), .q(adc)
  );

endmodule

// ==== rtl/periph_router.sv ====
/*
  peripheral chip select and miso routing, purely combinational
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module periph_router (
  input  logic                    cs_n,
  input  logic                    special_n,
  input  hub_pkg::mux_t           mux,
  input  logic                    hub_dout,
  input  logic [`HUB_PERIPHS-1:0] periph_miso,
  output logic [`HUB_PERIPHS-1:0] periph_cs_n,
  output logic                    miso
);

  // bit order adc02, flash, dac, adc03 from msb
  logic [`HUB_PERIPHS-1:0] sel;
  logic                    pass;

  assign sel = {mux.adc02, mux.flash, mux.dac, mux.adc03};

  // host talking to peripherals, not to the hub
  assign pass = ~cs_n & special_n;

  // never leak a hub command frame to a peripheral
  assign periph_cs_n = ~({`HUB_PERIPHS{pass}} & sel);

  // hub reply while special is low
  // otherwise wired-or of the selected lines
  assign miso = special_n ? |(sel & periph_miso) : hub_dout;

endmodule

// ==== rtl/spi_periph_hub.sv ====
/*
  spi peripheral hub top
  command path into the register bank, pass-through path to four peripherals
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module spi_periph_hub (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    special_n,
  input  logic                    mosi,
  output logic                    miso,
  output logic                    periph_sck,
  output logic                    periph_mosi,
  output logic [`HUB_PERIPHS-1:0] periph_cs_n,
  input  logic [`HUB_PERIPHS-1:0] periph_miso,
  output hub_pkg::led_t           led,
  output hub_pkg::dac_ctl_t       dac,
  output hub_pkg::rails_t         rails,
  output hub_pkg::ref_mux_t       ref_mux,
  output hub_pkg::adc_ctl_t       adc
);

  import hub_pkg::*;

  // clk domain events
  logic sck_rise;
  logic sck_fall;
  logic mosi_s;
  logic frame_start;
  logic frame_end;
  logic cmd_sel;

  // frame and register state
  logic  frame_valid;
  addr_t addr;
  val_t  val;
  mux_t  mux;
  logic  hub_dout;

  // sck and mosi go straight out, only cs is gated
  assign periph_sck  = sck;
  assign periph_mosi = mosi;

  //////////////////////////////
  // command path
  spi_edge_sync spi_edge_sync_i (
    .clk(clk), .arst_n(arst_n), .sck(sck), .cs_n(cs_n), .special_n(special_n),
    .mosi(mosi), .sck_rise(sck_rise), .sck_fall(sck_fall), .mosi_s(mosi_s),
    .frame_start(frame_start), .frame_end(frame_end), .cmd_sel(cmd_sel)
  );

  ctrl_frame_rx ctrl_frame_rx_i (
    .clk(clk), .arst_n(arst_n), .sck_rise(sck_rise), .mosi_s(mosi_s), .cmd_sel(cmd_sel),
    .frame_start(frame_start), .frame_end(frame_end), .frame_valid(frame_valid),
    .addr(addr), .val(val)
  );

  // readback runs beside the receiver
  ctrl_reply_tx ctrl_reply_tx_i (
    .clk(clk), .arst_n(arst_n), .sck_fall(sck_fall), .cmd_sel(cmd_sel),
    .frame_start(frame_start), .mux(mux), .led(led), .hub_dout(hub_dout)
  );

  ctrl_reg_bank ctrl_reg_bank_i (
    .clk(clk), .arst_n(arst_n), .frame_valid(frame_valid), .addr(addr), .val(val),
    .led(led), .mux(mux), .dac(dac), .rails(rails), .ref_mux(ref_mux), .adc(adc)
  );

  //////////////////////////////
  // pass-through path, raw pins
  periph_router periph_router_i (
    .cs_n(cs_n), .special_n(special_n), .mux(mux), .hub_dout(hub_dout),
    .periph_miso(periph_miso), .periph_cs_n(periph_cs_n), .miso(miso)
  );

endmodule

// ==== verif/hub_assertions.sv ====
/*
  bound checks on the hub
  select gating, strobe shape and reset values
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module hub_assertions (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    special_n,
  input logic [`HUB_PERIPHS-1:0] periph_cs_n,
  input logic                    frame_valid,
  input hub_pkg::led_t           led,
  input hub_pkg::mux_t           mux,
  input hub_pkg::dac_ctl_t       dac,
  input hub_pkg::rails_t         rails,
  input hub_pkg::ref_mux_t       ref_mux,
  input hub_pkg::adc_ctl_t       adc
);

  // command frames never reach a peripheral
  cs_gated: assert property (@(posedge clk) disable iff (!arst_n)
    !special_n |-> &periph_cs_n)
    else $error("peripheral select low while the hub select is low");

  // one cycle strobe
  strobe_single: assert property (@(posedge clk) disable iff (!arst_n)
    frame_valid |=> !frame_valid)
    else $error("frame_valid held for more than one cycle");

  // first cycle out of reset
  regs_cleared: assert property (@(posedge clk)
    $rose(arst_n) |-> ({led, mux, dac, rails, ref_mux, adc} == '0))
    else $error("control registers not zero after reset release");

endmodule

bind spi_periph_hub hub_assertions hub_assertions_i (
  .clk(clk), .arst_n(arst_n), .special_n(special_n), .periph_cs_n(periph_cs_n),
  .frame_valid(frame_valid), .led(led), .mux(mux), .dac(dac), .rails(rails),
  .ref_mux(ref_mux), .adc(adc)
);

// ==== verif/hub_tb.sv ====
/*
  testbench for the spi peripheral hub
  directed tests over command frames, reply readback and peripheral routing
*/

`timescale 1ns/1ps

`include "hub_macros.svh"

module hub_tb;

  import hub_pkg::*;

  localparam int clk_period_ns = 8;
  // sck half period in clk cycles, rtl needs at least 4
  localparam int sck_half_cyc = 6;
  // masks 6 x 5, drops 5, reply 3, routing 4
  localparam int num_frames = 6 * 5 + 5 + 3 + 4;
  localparam int timeout_ns = num_frames * 40 * sck_half_cyc * clk_period_ns + 4000;

  logic                    clk;
  logic                    arst_n;
  logic                    sck;
  logic                    cs_n;
  logic                    special_n;
  logic                    mosi;
  logic                    miso;
  logic                    periph_sck;
  logic                    periph_mosi;
  logic [`HUB_PERIPHS-1:0] periph_cs_n;
  logic [`HUB_PERIPHS-1:0] periph_miso;
  led_t                    led;
  dac_ctl_t                dac;
  rails_t                  rails;
  ref_mux_t                ref_mux;
  adc_ctl_t                adc;

  // reference model of the six fields
  logic [3:0] m_led;
  logic [3:0] m_mux;
  logic [3:0] m_dac;
  logic [3:0] m_rails;
  logic [3:0] m_ref_mux;
  logic [3:0] m_adc;

  int     err_cnt;
  int     check_cnt;
  integer seed = 32'h48677b84;

  initial clk = 1'b0;
  always #(clk_period_ns / 2) clk = ~clk;

  spi_periph_hub spi_periph_hub_i (
    .clk(clk), .arst_n(arst_n), .sck(sck), .cs_n(cs_n), .special_n(special_n),
    .mosi(mosi), .miso(miso), .periph_sck(periph_sck), .periph_mosi(periph_mosi),
    .periph_cs_n(periph_cs_n), .periph_miso(periph_miso), .led(led), .dac(dac),
    .rails(rails), .ref_mux(ref_mux), .adc(adc)
  );

  //////////////////////////////
  // compare tasks, one per result type
  task automatic check_reply(input string name, input reply_t exp, input reply_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s led: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_mux(input string name, input mux_t exp, input mux_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s mux: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_dac(input string name, input dac_ctl_t exp, input dac_ctl_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s dac: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rails(input string name, input rails_t exp, input rails_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s rails: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_ref_mux(input string name, input ref_mux_t exp, input ref_mux_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s ref_mux: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_adc(input string name, input adc_ctl_t exp, input adc_ctl_t act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s adc: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_periph(input string name, input logic [`HUB_PERIPHS-1:0] exp,
                              input logic [`HUB_PERIPHS-1:0] act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s periph_cs_n: expected %b, actual %b", name, exp, act);
    end
  endtask

  // single pins, miso and the sck and mosi pass-through
  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////
  // reference model
  // low nibble sets, high nibble clears, both flips
  function automatic logic [3:0] next_field(logic [3:0] old, val_t val);
    logic [3:0] nxt;
    for (int i = 0; i < 4; i++)
    begin
      case ({val[i+4], val[i]})
        2'b01: nxt[i] = 1'b1;
        2'b10: nxt[i] = 1'b0;
        2'b11: nxt[i] = ~old[i];
        default: nxt[i] = old[i];
      endcase
    end
    return nxt;
  endfunction

  task automatic clear_model();
    m_led     = '0;
    m_mux     = '0;
    m_dac     = '0;
    m_rails   = '0;
    m_ref_mux = '0;
    m_adc     = '0;
  endtask

  // unknown addresses leave the model alone
  task automatic model_write(input addr_t addr, input val_t val);
    case (addr)
      `HUB_ADDR_LED:      m_led     = next_field(m_led, val);
      `HUB_ADDR_MUX:      m_mux     = next_field(m_mux, val);
      `HUB_ADDR_DAC:      m_dac     = next_field(m_dac, val);
      `HUB_ADDR_RAILS:    m_rails   = next_field(m_rails, val);
      `HUB_ADDR_REF_MUX:  m_ref_mux = next_field(m_ref_mux, val);
      `HUB_ADDR_ADC:      m_adc     = next_field(m_adc, val);
      `HUB_ADDR_SOFT_RST: clear_model();
      default: ;
    endcase
  endtask

  task automatic check_regs(input string name);
    check_led(name, led_t'(m_led), led);
    // mux has no top level port
    check_mux(name, mux_t'(m_mux), spi_periph_hub_i.mux);
    check_dac(name, dac_ctl_t'(m_dac), dac);
    check_rails(name, rails_t'(m_rails), rails);
    check_ref_mux(name, ref_mux_t'(m_ref_mux), ref_mux);
    check_adc(name, adc_ctl_t'(m_adc), adc);
  endtask

  //////////////////////////////
  // spi driver, mode 0, msb first
  task automatic spi_xfer(input int nbits, input logic [31:0] data, input logic special,
                          output logic [31:0] rx);
    rx = '0;
    @(negedge clk);
    special_n = special;
    repeat (4) @(negedge clk);
    cs_n = 1'b0;
    // room for frame_start and the reply load
    repeat (sck_half_cyc) @(negedge clk);
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi = data[i];
      repeat (sck_half_cyc) @(negedge clk);
      // miso settled since the last falling sck
      rx = {rx[30:0], miso};
      sck = 1'b1;
      repeat (sck_half_cyc) @(negedge clk);
      sck = 1'b0;
    end
    repeat (sck_half_cyc) @(negedge clk);
    cs_n = 1'b1;
    repeat (2) @(negedge clk);
    special_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  // one command frame with reply check against the state before it
  task automatic send_cmd(input string name, input addr_t addr, input val_t val);
    logic [31:0] rx;
    reply_t      exp;
    exp = {`HUB_REV, m_mux, m_led};
    spi_xfer(`HUB_FRAME_BITS, {16'h0, addr, val}, 1'b0, rx);
    check_reply(name, exp, rx[15:0]);
    model_write(addr, val);
  endtask

  //////////////////////////////
  // directed tests
  task automatic test_reset();
    check_regs("reset");
    @(negedge clk);
    cs_n = 1'b0;
    @(posedge clk);
    // mux is clear, nothing may be selected
    check_periph("reset cs low", '1, periph_cs_n);
    @(negedge clk);
    cs_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task automatic test_masks();
    addr_t addrs [6];
    val_t  val;
    addrs = '{`HUB_ADDR_LED, `HUB_ADDR_MUX, `HUB_ADDR_DAC, `HUB_ADDR_RAILS,
              `HUB_ADDR_REF_MUX, `HUB_ADDR_ADC};
    for (int a = 0; a < 6; a++)
    begin
      for (int n = 0; n < 4; n++)
      begin
        val = val_t'($random(seed));
        send_cmd("masks", addrs[a], val);
        check_regs("masks");
      end
      // every bit in both masks
      send_cmd("toggle", addrs[a], 8'hff);
      check_regs("toggle");
    end
  endtask

  task automatic test_drops();
    logic [31:0] rx;
    // ends on a 0 bit, so the short frame below lines up as a led write
    send_cmd("unknown addr", 8'd13, 8'hfe);
    check_regs("unknown addr");
    // toggle frames so a wrong write always shows
    spi_xfer(15, {16'h0, `HUB_ADDR_LED, 8'hff}, 1'b0, rx);
    check_regs("short frame");
    // last 16 bits look like a valid led write
    spi_xfer(17, {15'h0, 1'b1, `HUB_ADDR_LED, 8'hff}, 1'b0, rx);
    check_regs("long frame");
    send_cmd("pre soft reset", `HUB_ADDR_LED, 8'h0f);
    send_cmd("soft reset", `HUB_ADDR_SOFT_RST, 8'h00);
    check_regs("soft reset");
  endtask

  task automatic test_reply();
    logic [31:0] rx;
    send_cmd("reply led", `HUB_ADDR_LED, 8'hfa);
    send_cmd("reply mux", `HUB_ADDR_MUX, 8'hf5);
    // explicit word, led a and mux 5 from the two writes above
    spi_xfer(`HUB_FRAME_BITS, {16'h0, 8'd0, 8'h00}, 1'b0, rx);
    check_reply("reply word", {`HUB_REV, 4'h5, 4'ha}, rx[15:0]);
  endtask

  task automatic test_routing();
    logic [3:0] sel;
    for (int k = 0; k < 4; k++)
    begin
      sel = 4'($random(seed));
      // clear the rest, set sel, mux ends up equal to sel
      send_cmd("route mux", `HUB_ADDR_MUX, {~sel, sel});
      check_regs("route mux");
      @(posedge clk);
      check_periph("route idle", '1, periph_cs_n);
      @(negedge clk);
      cs_n = 1'b0;
      for (int p = 0; p < 16; p++)
      begin
        @(negedge clk);
        periph_miso = 4'(p);
        // sck and mosi ride along through the pass-through
        sck  = p[0];
        mosi = p[1];
        @(posedge clk);
        check_periph("route cs", ~m_mux, periph_cs_n);
        check_bit("route miso", |(m_mux & periph_miso), miso);
        check_bit("route sck", p[0], periph_sck);
        check_bit("route mosi", p[1], periph_mosi);
      end
      // sck back to idle before the hub select drops
      @(negedge clk);
      sck  = 1'b0;
      mosi = 1'b0;
      // hub select held low blocks every peripheral
      @(negedge clk);
      special_n = 1'b0;
      @(posedge clk);
      check_periph("route special", '1, periph_cs_n);
      @(negedge clk);
      cs_n = 1'b1;
      periph_miso = '0;
      repeat (2) @(negedge clk);
      special_n = 1'b1;
      repeat (8) @(negedge clk);
    end
  endtask

  //////////////////////////////
  // main sequence
  initial
  begin
    err_cnt     = 0;
    check_cnt   = 0;
    arst_n      = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    clear_model();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);
    test_reset();
    test_masks();
    test_drops();
    test_reply();
    test_routing();
    $display("checks run %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // watchdog
  initial
  begin
    #(timeout_ns);
    $display("timeout: the tests did not complete within %0d ns", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/hub_pkg.sv
rtl/spi_edge_sync.sv
rtl/ctrl_frame_rx.sv
rtl/ctrl_reply_tx.sv
rtl/ctrl_field_reg.sv
rtl/ctrl_reg_bank.sv
rtl/periph_router.sv
rtl/spi_periph_hub.sv
verif/hub_assertions.sv
verif/hub_tb.sv

// ==== Makefile ====
# verilator flow for the spi peripheral hub

VERILATOR ?= verilator
TOP       ?= hub_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
